// ==== verilog/dma_pkg.sv ====
package dma_pkg;

  //////////////////////////////
  // data path and memory sizes
  //////////////////////////////
  localparam int DATA_W      = 32;
  localparam int LITE_ADDR_W = 12;
  localparam int MEM_DEPTH   = 256;
  localparam int MEM_AW      = 8;
  // length may reach MEM_DEPTH, one bit wider than an index
  localparam int LEN_W       = 9;

  // stream fifo between the engines
  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_AW     = 3;

  //////////////////////////////
  // host register map
  //////////////////////////////
  localparam logic [LITE_ADDR_W-1:0] REG_CONTROL = 12'h000;
  localparam logic [LITE_ADDR_W-1:0] REG_STATUS  = 12'h004;
  localparam logic [LITE_ADDR_W-1:0] REG_SRC     = 12'h008;
  localparam logic [LITE_ADDR_W-1:0] REG_DST     = 12'h00C;
  localparam logic [LITE_ADDR_W-1:0] REG_LENGTH  = 12'h010;
  // memory window, word index in byte address bits 9..2
  localparam logic [LITE_ADDR_W-1:0] MEM_BASE    = 12'h400;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // control and status bit positions
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_IRQ_EN_BIT = 1;
  localparam int STAT_BUSY_BIT   = 0;
  localparam int STAT_DONE_BIT   = 1;

endpackage

// ==== verilog/dma_regs.sv ====
`timescale 1ns/1ps

module dma_regs (
  input  logic                             clock,
  input  logic                             reset_lock,
  // axi4-lite write address and data
  input  logic [dma_pkg::LITE_ADDR_W-1:0]  awaddr,
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [dma_pkg::DATA_W-1:0]       wdata,
  input  logic [3:0]                       wstrb,
  input  logic                             wvalid,
  output logic                             wready,
  output logic [1:0]                       bresp,
  output logic                             bvalid,
  input  logic                             bready,
  // axi4-lite read
  input  logic [dma_pkg::LITE_ADDR_W-1:0]  araddr,
  input  logic                             arvalid,
  output logic                             arready,
  output logic [dma_pkg::DATA_W-1:0]       rdata,
  output logic [1:0]                       rresp,
  output logic                             rvalid,
  input  logic                             rready,
  output logic                             irq,
  // engine control
  output logic                             busy,
  output logic                             start,
  output logic [dma_pkg::MEM_AW-1:0]       src_index,
  output logic [dma_pkg::MEM_AW-1:0]       dst_index,
  output logic [dma_pkg::LEN_W-1:0]        length,
  input  logic                             xfer_done,
  // host side of the memory
  output logic [dma_pkg::MEM_AW-1:0]       host_rd_addr,
  input  logic [dma_pkg::DATA_W-1:0]       host_rd_data,
  output logic                             host_wr_en,
  output logic [dma_pkg::MEM_AW-1:0]       host_wr_addr,
  output logic [dma_pkg::DATA_W-1:0]       host_wr_data
);
  import dma_pkg::*;

  logic              irq_en;
  logic              done;
  // one ready register serves both aw and w, they always pulse together
  logic              wr_ready_q;
  logic              aw_hs;
  logic              ar_hs;
  logic              aw_is_mem;
  logic              ar_is_mem;
  logic              wr_go;
  logic              rd_go;
  // window read waiting out the memory latency
  logic              rd_mem_wait;
  logic [DATA_W-1:0] reg_rdata;

  // byte address falls inside the 1 KiB memory window
  function automatic logic in_window(input logic [LITE_ADDR_W-1:0] addr);
    return addr[LITE_ADDR_W-1:MEM_AW+2] == MEM_BASE[LITE_ADDR_W-1:MEM_AW+2];
  endfunction

  function automatic logic is_reg(input logic [LITE_ADDR_W-1:0] addr);
    return addr inside {REG_CONTROL, REG_STATUS, REG_SRC, REG_DST, REG_LENGTH};
  endfunction

  //////////////////////////////
  // handshakes and decode
  //////////////////////////////
  assign awready   = wr_ready_q;
  assign wready    = wr_ready_q;
  assign aw_hs     = awvalid & wvalid & wr_ready_q;
  assign ar_hs     = arvalid & arready;
  assign aw_is_mem = in_window(awaddr);
  assign ar_is_mem = in_window(araddr);

  // window held off while the engines own the memory
  assign wr_go = awvalid & wvalid & ~wr_ready_q & ~bvalid & ~(aw_is_mem & busy);
  // a write in flight may be a start, so hold window reads for it too
  assign rd_go = arvalid & ~arready & ~rvalid & ~rd_mem_wait
               & ~(ar_is_mem & (busy | aw_hs));

  // host memory port, only used while busy is low
  assign host_wr_en   = aw_hs & aw_is_mem;
  assign host_wr_addr = awaddr[MEM_AW+1:2];
  assign host_wr_data = wdata;
  assign host_rd_addr = araddr[MEM_AW+1:2];

  assign irq = done & irq_en;

  // register read mux, zero for anything unmapped
  always_comb begin
    reg_rdata = '0;
    case (araddr)
      REG_CONTROL: reg_rdata[CTRL_IRQ_EN_BIT] = irq_en;
      REG_STATUS: begin
        reg_rdata[STAT_BUSY_BIT] = busy;
        reg_rdata[STAT_DONE_BIT] = done;
      end
      REG_SRC:    reg_rdata[MEM_AW-1:0] = src_index;
      REG_DST:    reg_rdata[MEM_AW-1:0] = dst_index;
      REG_LENGTH: reg_rdata[LEN_W-1:0]  = length;
      default:    reg_rdata = '0;
    endcase
  end

  //////////////////////////////
  // control state
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset_lock) begin
      wr_ready_q  <= 1'b0;
      bvalid      <= 1'b0;
      arready     <= 1'b0;
      rvalid      <= 1'b0;
      rd_mem_wait <= 1'b0;
      irq_en      <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      start       <= 1'b0;
      src_index   <= '0;
      dst_index   <= '0;
      length      <= '0;
    end else begin
      wr_ready_q <= wr_go;
      arready    <= rd_go;
      start      <= 1'b0;

      // b channel
      if (aw_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      // register writes, window and unmapped fall to default
      if (aw_hs) begin
        case (awaddr)
          REG_CONTROL: begin
            irq_en <= wdata[CTRL_IRQ_EN_BIT];
            // start ignored while a copy runs
            if (wdata[CTRL_START_BIT] && !busy) begin
              if (length == '0) begin
                done <= 1'b1;
              end else begin
                busy  <= 1'b1;
                start <= 1'b1;
              end
            end
          end
          // write one to clear done
          REG_STATUS: if (wdata[STAT_DONE_BIT]) done <= 1'b0;
          REG_SRC:    src_index <= wdata[MEM_AW-1:0];
          REG_DST:    dst_index <= wdata[MEM_AW-1:0];
          REG_LENGTH: length    <= wdata[LEN_W-1:0];
          default: ;
        endcase
      end

      // end of copy wins over a clear in the same cycle
      if (xfer_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end

      // r channel
      if (ar_hs) begin
        rd_mem_wait <= ar_is_mem;
        rvalid      <= ~ar_is_mem;
      end else if (rd_mem_wait) begin
        rd_mem_wait <= 1'b0;
        rvalid      <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // response payload
  always_ff @(posedge clock) begin
    if (aw_hs) begin
      bresp <= (aw_is_mem || is_reg(awaddr)) ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_hs && !ar_is_mem) begin
      rdata <= reg_rdata;
      rresp <= is_reg(araddr) ? RESP_OKAY : RESP_SLVERR;
    end else if (rd_mem_wait) begin
      // memory word registered one cycle after the address
      rdata <= host_rd_data;
      rresp <= RESP_OKAY;
    end
  end

endmodule

// ==== verilog/dma_memory.sv ====
`timescale 1ns/1ps

module dma_memory (
  input  logic                        clock,
  input  logic                        busy,
  // host side, owner while idle
  input  logic [dma_pkg::MEM_AW-1:0]  host_rd_addr,
  output logic [dma_pkg::DATA_W-1:0]  host_rd_data,
  input  logic                        host_wr_en,
  input  logic [dma_pkg::MEM_AW-1:0]  host_wr_addr,
  input  logic [dma_pkg::DATA_W-1:0]  host_wr_data,
  // engine side, owner while busy
  input  logic [dma_pkg::MEM_AW-1:0]  eng_rd_addr,
  output logic [dma_pkg::DATA_W-1:0]  eng_rd_data,
  input  logic                        eng_wr_en,
  input  logic [dma_pkg::MEM_AW-1:0]  eng_wr_addr,
  input  logic [dma_pkg::DATA_W-1:0]  eng_wr_data
);
  import dma_pkg::*;

  logic [DATA_W-1:0] mem [MEM_DEPTH];
  logic [DATA_W-1:0] rd_q;

  logic [MEM_AW-1:0] rd_addr;
  logic              wr_en;
  logic [MEM_AW-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;

  //////////////////////////////
  // port ownership
  //////////////////////////////
  // mm2s takes the read port, s2mm the write port
  assign rd_addr = busy ? eng_rd_addr : host_rd_addr;
  assign wr_en   = busy ? eng_wr_en   : host_wr_en;
  assign wr_addr = busy ? eng_wr_addr : host_wr_addr;
  assign wr_data = busy ? eng_wr_data : host_wr_data;

  // single storage array, registered read
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_q <= mem[rd_addr];
  end

  // same read register seen by both sides
  // only the current owner looks at it
  assign host_rd_data = rd_q;
  assign eng_rd_data  = rd_q;

endmodule

// ==== verilog/mm2s_engine.sv ====
`timescale 1ns/1ps

module mm2s_engine (
  input  logic                        clock,
  input  logic                        reset_lock,
  input  logic                        start,
  input  logic [dma_pkg::MEM_AW-1:0]  src_index,
  input  logic [dma_pkg::LEN_W-1:0]   length,
  // memory read port
  output logic [dma_pkg::MEM_AW-1:0]  rd_addr,
  input  logic [dma_pkg::DATA_W-1:0]  rd_data,
  // outgoing stream
  output logic                        m_valid,
  input  logic                        m_ready,
  output logic [dma_pkg::DATA_W-1:0]  m_data,
  output logic                        m_last
);
  import dma_pkg::*;

  // reads still to issue
  logic [LEN_W-1:0]  issue_rem;
  logic [MEM_AW-1:0] rd_idx;
  // read issued last cycle, its word is on rd_data now
  logic              rd_pend;
  logic              pend_last;
  logic              issue;

  // one read outstanding, and only into a free output register
  // a stalled stream therefore stops reads with nothing dropped
  assign issue   = (issue_rem != '0) & ~rd_pend & (~m_valid | m_ready);
  assign rd_addr = rd_idx;

  //////////////////////////////
  // control
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset_lock) begin
      issue_rem <= '0;
      rd_pend   <= 1'b0;
      m_valid   <= 1'b0;
    end else begin
      if (start) begin
        issue_rem <= length;
      end else if (issue) begin
        issue_rem <= issue_rem - 1'b1;
      end
      rd_pend <= issue;
      // returned word always lands in an empty register
      if (rd_pend) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  // index wraps modulo memory depth by width
  always_ff @(posedge clock) begin
    if (start) begin
      rd_idx <= src_index;
    end else if (issue) begin
      rd_idx <= rd_idx + 1'b1;
    end
    if (issue) begin
      pend_last <= (issue_rem == LEN_W'(1));
    end
    if (rd_pend) begin
      m_data <= rd_data;
      m_last <= pend_last;
    end
  end

endmodule

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo (
  input  logic                        clock,
  input  logic                        reset_lock,
  // write side
  input  logic                        s_valid,
  output logic                        s_ready,
  input  logic [dma_pkg::DATA_W-1:0]  s_data,
  input  logic                        s_last,
  // read side
  output logic                        m_valid,
  input  logic                        m_ready,
  output logic [dma_pkg::DATA_W-1:0]  m_data,
  output logic                        m_last
);
  import dma_pkg::*;

  logic [DATA_W-1:0]  data_mem [FIFO_DEPTH];
  logic               last_mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               push;
  logic               pop;

  // back-pressure only when every slot is taken
  assign s_ready = count != (FIFO_AW+1)'(FIFO_DEPTH);
  assign m_valid = count != '0;
  assign m_data  = data_mem[rd_ptr];
  assign m_last  = last_mem[rd_ptr];

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  // pointers wrap by width
  always_ff @(posedge clock) begin
    if (!reset_lock) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // storage, data and last side by side
  always_ff @(posedge clock) begin
    if (push) begin
      data_mem[wr_ptr] <= s_data;
      last_mem[wr_ptr] <= s_last;
    end
  end

endmodule

// ==== verilog/s2mm_engine.sv ====
`timescale 1ns/1ps

module s2mm_engine (
  input  logic                        clock,
  input  logic                        reset_lock,
  input  logic                        start,
  input  logic [dma_pkg::MEM_AW-1:0]  dst_index,
  // incoming stream
  input  logic                        s_valid,
  output logic                        s_ready,
  input  logic [dma_pkg::DATA_W-1:0]  s_data,
  input  logic                        s_last,
  // memory write port
  output logic                        wr_en,
  output logic [dma_pkg::MEM_AW-1:0]  wr_addr,
  output logic [dma_pkg::DATA_W-1:0]  wr_data,
  output logic                        xfer_done
);
  import dma_pkg::*;

  logic              armed;
  logic [MEM_AW-1:0] wr_idx;
  logic              accept;

  // always ready while a copy is running
  assign s_ready = armed;
  assign accept  = s_valid & armed;

  // each word written in the cycle it is taken
  assign wr_en   = accept;
  assign wr_addr = wr_idx;
  assign wr_data = s_data;
  // flags the final write, so done rises right after it
  assign xfer_done = accept & s_last;

  //////////////////////////////
  // arm and word counter
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset_lock) begin
      armed <= 1'b0;
    end else if (start) begin
      armed <= 1'b1;
    end else if (xfer_done) begin
      armed <= 1'b0;
    end
  end

  // destination index, wraps at memory end
  always_ff @(posedge clock) begin
    if (start) begin
      wr_idx <= dst_index;
    end else if (accept) begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

endmodule

// ==== verilog/dma_loop_top.sv ====
`timescale 1ns/1ps

module dma_loop_top (
  input  logic                             clock,
  input  logic                             reset_lock,
  input  logic [dma_pkg::LITE_ADDR_W-1:0]  awaddr,
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [dma_pkg::DATA_W-1:0]       wdata,
  input  logic [3:0]                       wstrb,
  input  logic                             wvalid,
  output logic                             wready,
  output logic [1:0]                       bresp,
  output logic                             bvalid,
  input  logic                             bready,
  input  logic [dma_pkg::LITE_ADDR_W-1:0]  araddr,
  input  logic                             arvalid,
  output logic                             arready,
  output logic [dma_pkg::DATA_W-1:0]       rdata,
  output logic [1:0]                       rresp,
  output logic                             rvalid,
  input  logic                             rready,
  output logic                             irq
);
  import dma_pkg::*;

  // control between register block and engines
  logic              busy;
  logic              start;
  logic              xfer_done;
  logic [MEM_AW-1:0] src_index;
  logic [MEM_AW-1:0] dst_index;
  logic [LEN_W-1:0]  length;

  // host memory port
  logic [MEM_AW-1:0] host_rd_addr;
  logic [DATA_W-1:0] host_rd_data;
  logic              host_wr_en;
  logic [MEM_AW-1:0] host_wr_addr;
  logic [DATA_W-1:0] host_wr_data;

  // engine memory ports
  logic [MEM_AW-1:0] eng_rd_addr;
  logic [DATA_W-1:0] eng_rd_data;
  logic              eng_wr_en;
  logic [MEM_AW-1:0] eng_wr_addr;
  logic [DATA_W-1:0] eng_wr_data;

  // mm2s to fifo, fifo to s2mm
  logic              mm2s_valid;
  logic              mm2s_ready;
  logic [DATA_W-1:0] mm2s_data;
  logic              mm2s_last;
  logic              s2mm_valid;
  logic              s2mm_ready;
  logic [DATA_W-1:0] s2mm_data;
  logic              s2mm_last;

  dma_regs u_regs (
    .clock, .reset_lock,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .irq, .busy, .start, .src_index, .dst_index, .length, .xfer_done,
    .host_rd_addr, .host_rd_data, .host_wr_en, .host_wr_addr, .host_wr_data
  );

  dma_memory u_memory (
    .clock, .busy,
    .host_rd_addr, .host_rd_data, .host_wr_en, .host_wr_addr, .host_wr_data,
    .eng_rd_addr, .eng_rd_data, .eng_wr_en, .eng_wr_addr, .eng_wr_data
  );

  // read side of the loop
  mm2s_engine u_mm2s (
    .clock, .reset_lock, .start, .src_index, .length,
    .rd_addr (eng_rd_addr), .rd_data (eng_rd_data),
    .m_valid (mm2s_valid), .m_ready (mm2s_ready),
    .m_data  (mm2s_data),  .m_last  (mm2s_last)
  );

  stream_fifo u_fifo (
    .clock, .reset_lock,
    .s_valid (mm2s_valid), .s_ready (mm2s_ready),
    .s_data  (mm2s_data),  .s_last  (mm2s_last),
    .m_valid (s2mm_valid), .m_ready (s2mm_ready),
    .m_data  (s2mm_data),  .m_last  (s2mm_last)
  );

  // write side of the loop
  s2mm_engine u_s2mm (
    .clock, .reset_lock, .start, .dst_index,
    .s_valid (s2mm_valid), .s_ready (s2mm_ready),
    .s_data  (s2mm_data),  .s_last  (s2mm_last),
    .wr_en   (eng_wr_en),  .wr_addr (eng_wr_addr), .wr_data (eng_wr_data),
    .xfer_done
  );

endmodule

// ==== bench/tb_dma_loop.sv ====
`timescale 1ns/1ps

module tb_dma_loop;
  import dma_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic                   clock;
  logic                   reset_lock;
  logic [LITE_ADDR_W-1:0] awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [DATA_W-1:0]      wdata;
  logic [3:0]             wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [LITE_ADDR_W-1:0] araddr;
  logic                   arvalid;
  logic                   arready;
  logic [DATA_W-1:0]      rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;
  logic                   irq;

  integer            seed;
  // mirror of the dut memory
  logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
  // comparisons waiting for the checker
  string             name_q[$];
  logic [DATA_W-1:0] exp_q[$];
  logic [DATA_W-1:0] got_q[$];
  logic [1:0]        resp;
  logic [DATA_W-1:0] word;

  dma_loop_top u_dut (
    .clock, .reset_lock,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .irq
  );

  always #10 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic expect_value(input string name, input logic [DATA_W-1:0] exp_v,
                              input logic [DATA_W-1:0] got_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    got_q.push_back(got_v);
  endtask

  //////////////////////////////
  // checker process
  //////////////////////////////
  always @(negedge clock) begin : compare_words
    string             name;
    logic [DATA_W-1:0] exp_v;
    logic [DATA_W-1:0] got_v;
    while (exp_q.size() != 0) begin
      name  = name_q.pop_front();
      exp_v = exp_q.pop_front();
      got_v = got_q.pop_front();
      assert (got_v === exp_v) else begin
        abort_run($sformatf("MISMATCH %s expected 0x%08h got 0x%08h", name, exp_v, got_v));
      end
    end
  end

  // copy rule in stream order
  // overlapping words see earlier writes
  function automatic void ref_copy(input int src, input int dst, input int len);
    for (int i = 0; i < len; i++) begin
      ref_mem[MEM_AW'((dst + i) % MEM_DEPTH)] = ref_mem[MEM_AW'((src + i) % MEM_DEPTH)];
    end
  endfunction

  function automatic logic [LITE_ADDR_W-1:0] window_addr(input int idx);
    return MEM_BASE | LITE_ADDR_W'(idx * 4);
  endfunction

  function automatic logic [DATA_W-1:0] status_word(input logic busy_b, input logic done_b);
    logic [DATA_W-1:0] w;
    w = '0;
    w[STAT_BUSY_BIT] = busy_b;
    w[STAT_DONE_BIT] = done_b;
    return w;
  endfunction

  function automatic logic [DATA_W-1:0] control_word(input logic start_b, input logic irq_b);
    logic [DATA_W-1:0] w;
    w = '0;
    w[CTRL_START_BIT]  = start_b;
    w[CTRL_IRQ_EN_BIT] = irq_b;
    return w;
  endfunction

  //////////////////////////////
  // axi4-lite host
  //////////////////////////////
  task automatic axil_write(input logic [LITE_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic [1:0] resp_o);
    int n;
    @(posedge clock);
    #2;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(negedge clock);
    while (!awready) begin
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timeout waiting for the write address handshake");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    n = 0;
    @(negedge clock);
    while (!bvalid) begin
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timeout waiting for the write response");
      @(negedge clock);
    end
    resp_o = bresp;
    @(posedge clock);
    #2;
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [LITE_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data_o,
                           output logic [1:0] resp_o);
    int n;
    @(posedge clock);
    #2;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge clock);
    while (!arready) begin
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timeout waiting for the read address handshake");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    arvalid = 1'b0;
    rready  = 1'b1;
    n = 0;
    @(negedge clock);
    while (!rvalid) begin
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timeout waiting for read data");
      @(negedge clock);
    end
    data_o = rdata;
    resp_o = rresp;
    @(posedge clock);
    #2;
    rready = 1'b0;
  endtask

  task automatic write_ok(input logic [LITE_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [1:0] b_resp;
    axil_write(addr, data, b_resp);
    expect_value($sformatf("bresp at 0x%03h", addr), DATA_W'(RESP_OKAY), DATA_W'(b_resp));
  endtask

  task automatic read_expect(input logic [LITE_ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_v,
                             input string name);
    logic [DATA_W-1:0] r_data;
    logic [1:0]        r_resp;
    axil_read(addr, r_data, r_resp);
    expect_value($sformatf("rresp at 0x%03h", addr), DATA_W'(RESP_OKAY), DATA_W'(r_resp));
    expect_value(name, exp_v, r_data);
  endtask

  // whole window against the mirror
  task automatic compare_memory();
    for (int i = 0; i < MEM_DEPTH; i++) begin
      read_expect(window_addr(i), ref_mem[MEM_AW'(i)], $sformatf("mem[%0d]", i));
    end
  endtask

  // program registers and start
  // busy shows right after the start
  task automatic program_copy(input int src, input int dst, input int len, input logic irq_b);
    write_ok(REG_SRC, DATA_W'(src));
    write_ok(REG_DST, DATA_W'(dst));
    write_ok(REG_LENGTH, DATA_W'(len));
    write_ok(REG_CONTROL, control_word(1'b1, irq_b));
    read_expect(REG_STATUS, status_word(1'b1, 1'b0), "STATUS while busy");
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    @(negedge clock);
    while (!irq) begin
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timeout waiting for irq");
      @(negedge clock);
    end
  endtask

  // irq disabled, so done is seen only through STATUS
  task automatic wait_done_polled();
    int                polls;
    logic [DATA_W-1:0] status;
    polls  = 0;
    status = '0;
    while (!status[STAT_DONE_BIT]) begin
      polls++;
      if (polls > TIMEOUT_CYCLES / 8) abort_run("timeout polling STATUS for done");
      axil_read(REG_STATUS, status, resp);
      expect_value("irq", '0, DATA_W'(irq));
    end
  endtask

  // every queued comparison taken by the checker
  task automatic wait_checker_idle();
    int n;
    n = 0;
    @(negedge clock);
    while (exp_q.size() != 0) begin
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("timeout waiting for the checker to drain");
      @(negedge clock);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    clock      = 1'b0;
    reset_lock = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = 4'hF;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    seed       = 32'h8cf5a31d;
    repeat (8) @(posedge clock);
    #2;
    reset_lock = 1'b1;

    // random fill through the window and read back
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[MEM_AW'(i)] = $random(seed);
      write_ok(window_addr(i), ref_mem[MEM_AW'(i)]);
    end
    compare_memory();
    write_ok(REG_SRC, 32'h5A);
    write_ok(REG_DST, 32'hC3);
    write_ok(REG_LENGTH, 32'h100);
    read_expect(REG_SRC, 32'h5A, "SRC");
    read_expect(REG_DST, 32'hC3, "DST");
    read_expect(REG_LENGTH, 32'h100, "LENGTH");

    // 16 word copy with irq enabled
    program_copy(0, 64, 16, 1'b1);
    wait_irq();
    read_expect(REG_STATUS, status_word(1'b0, 1'b1), "STATUS after copy");
    ref_copy(0, 64, 16);
    compare_memory();
    write_ok(REG_STATUS, status_word(1'b0, 1'b1));
    expect_value("irq", '0, DATA_W'(irq));

    // source wraps past the top of memory
    program_copy(200, 40, 100, 1'b1);
    wait_irq();
    read_expect(REG_STATUS, status_word(1'b0, 1'b1), "STATUS after copy");
    ref_copy(200, 40, 100);
    compare_memory();
    write_ok(REG_STATUS, status_word(1'b0, 1'b1));

    // irq masked and done sticky until cleared
    program_copy(10, 150, 20, 1'b0);
    wait_done_polled();
    read_expect(REG_STATUS, status_word(1'b0, 1'b1), "STATUS after copy");
    expect_value("irq", '0, DATA_W'(irq));
    write_ok(REG_STATUS, status_word(1'b0, 1'b1));
    read_expect(REG_STATUS, '0, "STATUS after clear");
    ref_copy(10, 150, 20);
    compare_memory();

    // zero length finishes at once
    write_ok(REG_LENGTH, '0);
    write_ok(REG_CONTROL, control_word(1'b1, 1'b0));
    read_expect(REG_STATUS, status_word(1'b0, 1'b1), "STATUS zero length");
    compare_memory();
    write_ok(REG_STATUS, status_word(1'b0, 1'b1));

    // unmapped offset
    axil_read(12'h200, word, resp);
    expect_value("rresp at 0x200", DATA_W'(RESP_SLVERR), DATA_W'(resp));
    expect_value("rdata at 0x200", '0, word);
    axil_write(12'h200, 32'hFFFF_FFFF, resp);
    expect_value("bresp at 0x200", DATA_W'(RESP_SLVERR), DATA_W'(resp));
    read_expect(REG_CONTROL, control_word(1'b0, 1'b0), "CONTROL");
    read_expect(REG_SRC, 32'd10, "SRC");
    read_expect(REG_DST, 32'd150, "DST");
    read_expect(REG_LENGTH, '0, "LENGTH");
    read_expect(REG_STATUS, '0, "STATUS");

    wait_checker_idle();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== flist.f ====
verilog/dma_pkg.sv
verilog/dma_regs.sv
verilog/dma_memory.sv
verilog/mm2s_engine.sv
verilog/stream_fifo.sv
verilog/s2mm_engine.sv
verilog/dma_loop_top.sv
bench/tb_dma_loop.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_dma_loop -f flist.f -o sim_dma_loop \
  && ./obj_dir/sim_dma_loop > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

grep -q '^\*\* PASS \*\*$' sim.log \
  && echo "simulation passed" \
  || { cat sim.log; exit 1; }
